/* hw/memsys_pkg.sv */
`default_nettype none

package memsys_pkg;

    // Data and address width
    localparam int XLEN  = 32;
    localparam int BYTES = XLEN / 8;

    // Direct-mapped caches with one word per line
    localparam int CACHE_LINES = 16;
    localparam int IDX_LSB     = 2;
    localparam int IDX_W       = $clog2(CACHE_LINES);
    localparam int TAG_LSB     = IDX_LSB + IDX_W;
    localparam int TAG_W       = XLEN - TAG_LSB;

    // Main memory, word addressed
    localparam int MEM_WORDS   = 1024;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY = 4;
    localparam int MEM_CNT_W   = $clog2(MEM_LATENCY);
    // Down-counter start, ack lands MEM_LATENCY cycles after accept
    localparam logic [MEM_CNT_W-1:0] MEM_CNT_INIT = MEM_CNT_W'(MEM_LATENCY - 2);

    // Boot window 0x0000_1xxx, first words populated only
    localparam logic [XLEN-1:0] BOOT_BASE  = 32'h0000_1000;
    localparam logic [XLEN-1:0] BOOT_MASK  = 32'hffff_f000;
    localparam int              BOOT_WORDS = 16;
    localparam int              BOOT_IDX_W = $clog2(BOOT_WORDS);

    typedef struct packed {
        logic [XLEN-1:0]  addr;
        logic             req;
        logic             req_kill;
    } if2icache_s;

    typedef struct packed {
        logic [XLEN-1:0]  r_data;
        logic             ack;
    } icache2if_s;

    typedef struct packed {
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  w_data;
        logic [BYTES-1:0] sel_byte;
        logic             w_en;
        logic             req;
    } dbus2mem_s;

    typedef struct packed {
        logic [XLEN-1:0]  r_data;
        logic             ack;
    } mem2dbus_s;

    typedef struct packed {
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  w_data;
        logic [BYTES-1:0] sel_byte;
        logic             w_en;
        logic             req;
    } cache2mem_s;

    typedef struct packed {
        logic [XLEN-1:0]  r_data;
        logic             ack;
    } mem2cache_s;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_DCACHE,
        ARB_ICACHE,
        ARB_IKILL
    } arb_state_e;

endpackage

`default_nettype wire

/* hw/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire memsys_pkg::if2icache_s if2icache_i,
    output memsys_pkg::icache2if_s   icache2if_o,
    input  wire memsys_pkg::mem2cache_s mem2icache_i,
    output memsys_pkg::cache2mem_s   icache2mem_o
);

    logic [memsys_pkg::TAG_W-1:0]       tag_q  [memsys_pkg::CACHE_LINES];
    logic [memsys_pkg::XLEN-1:0]        data_q [memsys_pkg::CACHE_LINES];
    logic [memsys_pkg::CACHE_LINES-1:0] valid_ff;

    logic [memsys_pkg::IDX_W-1:0] idx;
    logic [memsys_pkg::TAG_W-1:0] tag;
    logic                         hit;
    logic                         accept;
    logic                         fill;
    logic                         miss_ff;
    logic                         ack_ff;
    logic [memsys_pkg::XLEN-1:0]  r_data_ff;

    assign idx = if2icache_i.addr[memsys_pkg::TAG_LSB-1:memsys_pkg::IDX_LSB];
    assign tag = if2icache_i.addr[memsys_pkg::XLEN-1:memsys_pkg::TAG_LSB];
    assign hit = valid_ff[idx] && (tag_q[idx] == tag);

    // No new fetch while a miss is open or the ack is on the port
    assign accept = if2icache_i.req && !miss_ff && !ack_ff;

    // A kill wins over a memory response in the same cycle
    assign fill = miss_ff && mem2icache_i.ack && !if2icache_i.req_kill;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_ff <= '0;
            miss_ff  <= 1'b0;
            ack_ff   <= 1'b0;
        end else begin
            ack_ff <= (accept && hit) || fill;
            if (if2icache_i.req_kill || fill) begin
                miss_ff <= 1'b0;
            end else if (accept && !hit) begin
                miss_ff <= 1'b1;
            end
            if (fill) begin
                valid_ff[idx] <= 1'b1;
            end
        end
    end

    // Line arrays and returned word
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem2icache_i.r_data;
            r_data_ff   <= mem2icache_i.r_data;
        end else if (accept) begin
            r_data_ff   <= data_q[idx];
        end
    end

    assign icache2if_o.r_data = r_data_ff;
    assign icache2if_o.ack    = ack_ff;

    // Miss request, dropped at once on a kill
    assign icache2mem_o.addr     = {if2icache_i.addr[memsys_pkg::XLEN-1:2], 2'b00};
    assign icache2mem_o.w_data   = '0;
    assign icache2mem_o.sel_byte = '1;
    assign icache2mem_o.w_en     = 1'b0;
    assign icache2mem_o.req      = miss_ff && !if2icache_i.req_kill;

endmodule

`default_nettype wire

/* hw/dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire memsys_pkg::dbus2mem_s dbus2mem_i,
    output memsys_pkg::mem2dbus_s    dcache2dbus_o,
    input  wire memsys_pkg::mem2cache_s mem2dcache_i,
    output memsys_pkg::cache2mem_s   dcache2mem_o
);

    logic [memsys_pkg::TAG_W-1:0]       tag_q  [memsys_pkg::CACHE_LINES];
    logic [memsys_pkg::XLEN-1:0]        data_q [memsys_pkg::CACHE_LINES];
    logic [memsys_pkg::CACHE_LINES-1:0] valid_ff;

    logic [memsys_pkg::IDX_W-1:0] idx;
    logic [memsys_pkg::TAG_W-1:0] tag;
    logic                         hit;
    logic                         accept;
    logic                         done;
    logic                         fill;
    logic                         upd;
    logic                         pend_ff;
    logic                         ack_ff;
    logic [memsys_pkg::XLEN-1:0]  r_data_ff;
    logic [memsys_pkg::XLEN-1:0]  merged;

    assign idx = dbus2mem_i.addr[memsys_pkg::TAG_LSB-1:memsys_pkg::IDX_LSB];
    assign tag = dbus2mem_i.addr[memsys_pkg::XLEN-1:memsys_pkg::TAG_LSB];
    assign hit = valid_ff[idx] && (tag_q[idx] == tag);

    assign accept = dbus2mem_i.req && !pend_ff && !ack_ff;
    assign done   = pend_ff && mem2dcache_i.ack;

    // Read miss fills the line, write hit patches it
    assign fill = done && !dbus2mem_i.w_en;
    assign upd  = done && dbus2mem_i.w_en && hit;

    // Store bytes merged over the current line
    always_comb begin
        merged = data_q[idx];
        for (int b = 0; b < memsys_pkg::BYTES; b++) begin
            if (dbus2mem_i.sel_byte[b]) begin
                merged[8*b +: 8] = dbus2mem_i.w_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_ff <= '0;
            pend_ff  <= 1'b0;
            ack_ff   <= 1'b0;
        end else begin
            ack_ff <= (accept && !dbus2mem_i.w_en && hit) || done;
            if (done) begin
                pend_ff <= 1'b0;
            end else if (accept && (dbus2mem_i.w_en || !hit)) begin
                // Every write and every read miss goes to main memory
                pend_ff <= 1'b1;
            end
            if (fill) begin
                valid_ff[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem2dcache_i.r_data;
            r_data_ff   <= mem2dcache_i.r_data;
        end else if (upd) begin
            data_q[idx] <= merged;
        end else if (accept) begin
            r_data_ff   <= data_q[idx];
        end
    end

    assign dcache2dbus_o.r_data = r_data_ff;
    assign dcache2dbus_o.ack    = ack_ff;

    // Bus fields are held by the requester until the ack
    assign dcache2mem_o.addr     = {dbus2mem_i.addr[memsys_pkg::XLEN-1:2], 2'b00};
    assign dcache2mem_o.w_data   = dbus2mem_i.w_data;
    assign dcache2mem_o.sel_byte = dbus2mem_i.sel_byte;
    assign dcache2mem_o.w_en     = dbus2mem_i.w_en;
    assign dcache2mem_o.req      = pend_ff;

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire memsys_pkg::cache2mem_s icache2mem_i,
    input  wire memsys_pkg::cache2mem_s dcache2mem_i,
    input  wire                      req_kill_i,
    output memsys_pkg::mem2cache_s   mem2icache_o,
    output memsys_pkg::mem2cache_s   mem2dcache_o,
    output memsys_pkg::cache2mem_s   cache2mem_o,
    input  wire memsys_pkg::mem2cache_s mem2cache_i
);

    memsys_pkg::arb_state_e state_ff;
    memsys_pkg::arb_state_e state_next;
    memsys_pkg::cache2mem_s req_ff;
    memsys_pkg::cache2mem_s req_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_ff <= memsys_pkg::ARB_IDLE;
            req_ff   <= '0;
        end else begin
            state_ff <= state_next;
            req_ff   <= req_next;
        end
    end

    always_comb begin
        state_next   = state_ff;
        req_next     = req_ff;
        mem2icache_o = '0;
        mem2dcache_o = '0;

        case (state_ff)
            memsys_pkg::ARB_IDLE: begin
                // Data side first, fetch waits with its req held
                if (dcache2mem_i.req) begin
                    req_next   = dcache2mem_i;
                    state_next = memsys_pkg::ARB_DCACHE;
                end else if (icache2mem_i.req) begin
                    req_next   = icache2mem_i;
                    state_next = memsys_pkg::ARB_ICACHE;
                end
            end

            memsys_pkg::ARB_DCACHE: begin
                if (mem2cache_i.ack) begin
                    mem2dcache_o = mem2cache_i;
                    req_next.req = 1'b0;
                    state_next   = memsys_pkg::ARB_IDLE;
                end
            end

            memsys_pkg::ARB_ICACHE: begin
                if (req_kill_i) begin
                    if (mem2cache_i.ack) begin
                        req_next.req = 1'b0;
                        state_next   = memsys_pkg::ARB_IDLE;
                    end else begin
                        state_next   = memsys_pkg::ARB_IKILL;
                    end
                end else if (mem2cache_i.ack) begin
                    mem2icache_o = mem2cache_i;
                    req_next.req = 1'b0;
                    state_next   = memsys_pkg::ARB_IDLE;
                end
            end

            memsys_pkg::ARB_IKILL: begin
                // Memory still owes an ack, swallow it
                if (mem2cache_i.ack) begin
                    req_next.req = 1'b0;
                    state_next   = memsys_pkg::ARB_IDLE;
                end
            end

            default: begin
                state_next = memsys_pkg::ARB_IDLE;
            end
        endcase
    end

    assign cache2mem_o = req_ff;

endmodule

`default_nettype wire

/* hw/main_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module main_mem (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire memsys_pkg::cache2mem_s cache2mem_i,
    output memsys_pkg::mem2cache_s   mem2cache_o
);

    logic [memsys_pkg::XLEN-1:0]      mem_q [memsys_pkg::MEM_WORDS];
    logic [memsys_pkg::MEM_IDX_W-1:0] widx;
    logic [memsys_pkg::MEM_CNT_W-1:0] cnt_ff;
    logic                             busy_ff;
    logic                             ack_ff;
    logic                             accept;
    logic                             done;
    logic [memsys_pkg::XLEN-1:0]      r_data_ff;

    assign widx   = cache2mem_i.addr[memsys_pkg::MEM_IDX_W+1:2];
    // Req is still high in the ack cycle, so that cycle is skipped
    assign accept = cache2mem_i.req && !busy_ff && !ack_ff;
    assign done   = busy_ff && (cnt_ff == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_ff <= 1'b0;
            ack_ff  <= 1'b0;
            cnt_ff  <= '0;
        end else begin
            ack_ff <= done;
            if (accept) begin
                busy_ff <= 1'b1;
                cnt_ff  <= memsys_pkg::MEM_CNT_INIT;
            end else if (done) begin
                busy_ff <= 1'b0;
            end else if (busy_ff) begin
                cnt_ff  <= cnt_ff - 1'b1;
            end
        end
    end

    // Writes land at accept, read data sampled on the last count
    always_ff @(posedge clk) begin
        if (accept && cache2mem_i.w_en) begin
            for (int b = 0; b < memsys_pkg::BYTES; b++) begin
                if (cache2mem_i.sel_byte[b]) begin
                    mem_q[widx][8*b +: 8] <= cache2mem_i.w_data[8*b +: 8];
                end
            end
        end
        if (done) begin
            r_data_ff <= mem_q[widx];
        end
    end

    assign mem2cache_o.r_data = r_data_ff;
    assign mem2cache_o.ack    = ack_ff;

endmodule

`default_nettype wire

/* hw/boot_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire memsys_pkg::if2icache_s if2bmem_i,
    output memsys_pkg::icache2if_s   bmem2if_o,
    input  wire memsys_pkg::dbus2mem_s dbus2bmem_i,
    output memsys_pkg::mem2dbus_s    bmem2dbus_o
);

    logic [memsys_pkg::XLEN-1:0] rom_q [memsys_pkg::BOOT_WORDS];
    logic                        i_ack_ff;
    logic                        d_ack_ff;
    logic [memsys_pkg::XLEN-1:0] i_data_ff;
    logic [memsys_pkg::XLEN-1:0] d_data_ff;

    initial begin
        $readmemh("boot_rom.hex", rom_q);
    end

    // One ack per request on each port, stores are acked and dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            i_ack_ff <= 1'b0;
            d_ack_ff <= 1'b0;
        end else begin
            i_ack_ff <= if2bmem_i.req && !i_ack_ff;
            d_ack_ff <= dbus2bmem_i.req && !d_ack_ff;
        end
    end

    always_ff @(posedge clk) begin
        i_data_ff <= rom_q[if2bmem_i.addr[memsys_pkg::BOOT_IDX_W+1:2]];
        d_data_ff <= rom_q[dbus2bmem_i.addr[memsys_pkg::BOOT_IDX_W+1:2]];
    end

    assign bmem2if_o.r_data   = i_data_ff;
    assign bmem2if_o.ack      = i_ack_ff;
    assign bmem2dbus_o.r_data = d_data_ff;
    assign bmem2dbus_o.ack    = d_ack_ff;

endmodule

`default_nettype wire

/* hw/memsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module memsys_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire memsys_pkg::if2icache_s if2icache_i,
    output memsys_pkg::icache2if_s   icache2if_o,
    input  wire memsys_pkg::dbus2mem_s dbus2mem_i,
    input  wire                      dmem_sel_i,
    input  wire                      bmem_sel_i,
    output memsys_pkg::mem2dbus_s    dcache2dbus_o,
    output memsys_pkg::mem2dbus_s    bmem2dbus_o
);

    memsys_pkg::if2icache_s if2ic;
    memsys_pkg::if2icache_s if2bm;
    memsys_pkg::icache2if_s ic2if;
    memsys_pkg::icache2if_s bm2if;
    memsys_pkg::dbus2mem_s  dbus2dc;
    memsys_pkg::dbus2mem_s  dbus2bm;
    memsys_pkg::cache2mem_s ic2mem;
    memsys_pkg::cache2mem_s dc2mem;
    memsys_pkg::cache2mem_s arb2mem;
    memsys_pkg::mem2cache_s mem2ic;
    memsys_pkg::mem2cache_s mem2dc;
    memsys_pkg::mem2cache_s mem2arb;
    logic                   boot_hit;

    // Fetch address inside the boot window
    assign boot_hit = (if2icache_i.addr & memsys_pkg::BOOT_MASK) == memsys_pkg::BOOT_BASE;

    always_comb begin
        if2ic          = if2icache_i;
        if2ic.req      = if2icache_i.req && !boot_hit;
        if2bm          = if2icache_i;
        if2bm.req      = if2icache_i.req && boot_hit;
        dbus2dc        = dbus2mem_i;
        dbus2dc.req    = dbus2mem_i.req && dmem_sel_i;
        dbus2bm        = dbus2mem_i;
        dbus2bm.req    = dbus2mem_i.req && bmem_sel_i;
    end

    icache icache_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .if2icache_i  (if2ic),
        .icache2if_o  (ic2if),
        .mem2icache_i (mem2ic),
        .icache2mem_o (ic2mem)
    );

    dcache dcache_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .dbus2mem_i    (dbus2dc),
        .dcache2dbus_o (dcache2dbus_o),
        .mem2dcache_i  (mem2dc),
        .dcache2mem_o  (dc2mem)
    );

    mem_arbiter mem_arbiter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .icache2mem_i (ic2mem),
        .dcache2mem_i (dc2mem),
        .req_kill_i   (if2ic.req_kill),
        .mem2icache_o (mem2ic),
        .mem2dcache_o (mem2dc),
        .cache2mem_o  (arb2mem),
        .mem2cache_i  (mem2arb)
    );

    main_mem main_mem_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cache2mem_i (arb2mem),
        .mem2cache_o (mem2arb)
    );

    boot_rom boot_rom_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .if2bmem_i   (if2bm),
        .bmem2if_o   (bm2if),
        .dbus2bmem_i (dbus2bm),
        .bmem2dbus_o (bmem2dbus_o)
    );

    // Only one fetch is ever outstanding, so the acks never collide
    assign icache2if_o = bm2if.ack ? bm2if : ic2if;

endmodule

`default_nettype wire

/* tb/memsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module memsys_tb;

    localparam int ACK_TIMEOUT = 16 * memsys_pkg::MEM_LATENCY + 16;

    logic                   clk;
    logic                   rst_n;
    memsys_pkg::if2icache_s if2icache;
    memsys_pkg::icache2if_s icache2if;
    memsys_pkg::dbus2mem_s  dbus;
    logic                   dmem_sel;
    logic                   bmem_sel;
    memsys_pkg::mem2dbus_s  dcache2dbus;
    memsys_pkg::mem2dbus_s  bmem2dbus;

    // Reference model
    logic [31:0] shadow   [memsys_pkg::MEM_WORDS];
    logic [31:0] boot_img [memsys_pkg::BOOT_WORDS];
    logic [31:0] rand_addr [8];

    // Expected responses in issue order
    memsys_pkg::icache2if_s fetch_exp_q[$];
    memsys_pkg::mem2dbus_s  dbus_exp_q[$];
    bit                     dbus_chk_q[$];
    memsys_pkg::mem2dbus_s  bmem_exp_q[$];

    int seed = 32'haa30_3010;
    int err_mismatch = 0;
    int err_unexpected = 0;
    int err_timeout = 0;
    int err_idle = 0;

    memsys_top memsys_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .if2icache_i   (if2icache),
        .icache2if_o   (icache2if),
        .dbus2mem_i    (dbus),
        .dmem_sel_i    (dmem_sel),
        .bmem_sel_i    (bmem_sel),
        .dcache2dbus_o (dcache2dbus),
        .bmem2dbus_o   (bmem2dbus)
    );

    always #4 clk = ~clk;

    // Expected word for any address in the boot image or main memory
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        if (addr[31:12] == 20'h0_0001) begin
            return boot_img[addr[5:2]];
        end
        return shadow[addr[11:2]];
    endfunction

    function automatic logic data_ack(input logic to_boot);
        return to_boot ? bmem2dbus.ack : dcache2dbus.ack;
    endfunction

    task automatic check_fetch(input memsys_pkg::icache2if_s got,
                               input memsys_pkg::icache2if_s want);
        if (got !== want) begin
            $display("mismatch icache2if_o: got %h expected %h", got.r_data, want.r_data);
            err_mismatch++;
        end
    endtask

    task automatic check_dbus(input string sig, input memsys_pkg::mem2dbus_s got,
                              input memsys_pkg::mem2dbus_s want);
        if (got !== want) begin
            $display("mismatch %s: got %h expected %h", sig, got.r_data, want.r_data);
            err_mismatch++;
        end
    endtask

    task automatic fetch_word(input logic [31:0] addr);
        memsys_pkg::icache2if_s want;
        int cyc;
        want.r_data = ref_word(addr);
        want.ack    = 1'b1;
        fetch_exp_q.push_back(want);
        if2icache.addr = addr;
        if2icache.req  = 1'b1;
        cyc = 0;
        @(negedge clk);
        while (icache2if.ack !== 1'b1 && cyc < ACK_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (icache2if.ack !== 1'b1) begin
            $display("error: fetch from %h got no ack within %0d cycles", addr, ACK_TIMEOUT);
            err_timeout++;
            void'(fetch_exp_q.pop_back());
        end
        if2icache.req = 1'b0;
    endtask

    // Fetch miss abandoned by a kill pulse and never acked
    task automatic kill_fetch(input logic [31:0] addr);
        if2icache.addr = addr;
        if2icache.req  = 1'b1;
        repeat (3) @(negedge clk);
        if2icache.req      = 1'b0;
        if2icache.req_kill = 1'b1;
        @(negedge clk);
        if2icache.req_kill = 1'b0;
        repeat (4 * memsys_pkg::MEM_LATENCY + 4) @(negedge clk);
    endtask

    task automatic dbus_cycle(input logic to_boot);
        int cyc;
        dmem_sel = !to_boot;
        bmem_sel = to_boot;
        dbus.req = 1'b1;
        cyc = 0;
        @(negedge clk);
        while (data_ack(to_boot) !== 1'b1 && cyc < ACK_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (data_ack(to_boot) !== 1'b1) begin
            $display("error: data bus access to %h got no ack within %0d cycles",
                     dbus.addr, ACK_TIMEOUT);
            err_timeout++;
            if (to_boot) begin
                void'(bmem_exp_q.pop_back());
            end else begin
                void'(dbus_exp_q.pop_back());
                void'(dbus_chk_q.pop_back());
            end
        end
        dbus.req = 1'b0;
        dmem_sel = 1'b0;
        bmem_sel = 1'b0;
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] sel);
        memsys_pkg::mem2dbus_s none;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                shadow[addr[11:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
        none = '0;
        dbus_exp_q.push_back(none);
        dbus_chk_q.push_back(1'b0);
        dbus.addr     = addr;
        dbus.w_data   = data;
        dbus.sel_byte = sel;
        dbus.w_en     = 1'b1;
        dbus_cycle(1'b0);
    endtask

    task automatic load_word(input logic [31:0] addr);
        memsys_pkg::mem2dbus_s want;
        want.r_data = ref_word(addr);
        want.ack    = 1'b1;
        dbus_exp_q.push_back(want);
        dbus_chk_q.push_back(1'b1);
        dbus.addr     = addr;
        dbus.w_data   = '0;
        dbus.sel_byte = 4'hf;
        dbus.w_en     = 1'b0;
        dbus_cycle(1'b0);
    endtask

    task automatic boot_load(input logic [31:0] addr);
        memsys_pkg::mem2dbus_s want;
        want.r_data = ref_word(addr);
        want.ack    = 1'b1;
        bmem_exp_q.push_back(want);
        dbus.addr     = addr;
        dbus.w_data   = '0;
        dbus.sel_byte = 4'hf;
        dbus.w_en     = 1'b0;
        dbus_cycle(1'b1);
    endtask

    // Every ack is matched against the oldest expected response
    always @(negedge clk) begin : compare
        memsys_pkg::mem2dbus_s want_d;
        if (rst_n === 1'b1) begin
            if (icache2if.ack === 1'b1) begin
                if (fetch_exp_q.size() == 0) begin
                    $display("error: fetch ack at %0t with no fetch outstanding", $time);
                    err_unexpected++;
                end else begin
                    check_fetch(icache2if, fetch_exp_q.pop_front());
                end
            end
            if (dcache2dbus.ack === 1'b1) begin
                if (dbus_exp_q.size() == 0) begin
                    $display("error: data cache ack at %0t with no access outstanding", $time);
                    err_unexpected++;
                end else begin
                    want_d = dbus_exp_q.pop_front();
                    if (dbus_chk_q.pop_front()) begin
                        check_dbus("dcache2dbus_o", dcache2dbus, want_d);
                    end
                end
            end
            if (bmem2dbus.ack === 1'b1) begin
                if (bmem_exp_q.size() == 0) begin
                    $display("error: boot ROM ack at %0t with no access outstanding", $time);
                    err_unexpected++;
                end else begin
                    check_dbus("bmem2dbus_o", bmem2dbus, bmem_exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        if2icache = '0;
        dbus      = '0;
        dmem_sel  = 1'b0;
        bmem_sel  = 1'b0;
        $readmemh("boot_rom.hex", boot_img);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Quiet after reset
        repeat (10) begin
            @(negedge clk);
            if (icache2if.ack !== 1'b0 || dcache2dbus.ack !== 1'b0
                    || bmem2dbus.ack !== 1'b0) begin
                $display("error: an ack output is not low while no request is made");
                err_idle++;
            end
        end

        // Full words first so later masked stores never leave unknown bytes
        for (int i = 0; i < 8; i++) begin
            rand_addr[i] = $random(seed) & 32'h0000_07fc;
            store_word(rand_addr[i], $random(seed), 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            store_word(rand_addr[i], $random(seed), 4'($random(seed)));
        end
        for (int i = 0; i < 8; i++) begin
            load_word(rand_addr[i]);
            load_word(rand_addr[i]);
        end
        for (int i = 0; i < 8; i++) begin
            store_word(rand_addr[i], $random(seed), 4'($random(seed)));
            load_word(rand_addr[i]);
        end

        // Same index, different tags
        store_word(32'h0000_0804, 32'h1111_aaaa, 4'hf);
        store_word(32'h0000_0844, 32'h2222_bbbb, 4'hf);
        for (int i = 0; i < 3; i++) begin
            load_word(32'h0000_0804);
            load_word(32'h0000_0844);
        end
        // 0x844 resident here, 0x804 evicted
        store_word(32'h0000_0844, 32'h3333_cccc, 4'b0110);
        store_word(32'h0000_0804, 32'h4444_dddd, 4'b1001);
        load_word(32'h0000_0844);
        load_word(32'h0000_0804);
        load_word(32'h0000_0844);

        // Code written over the data bus, then fetched
        for (int i = 0; i < 6; i++) begin
            store_word(32'h0000_0900 + 32'(4 * i), $random(seed), 4'hf);
        end
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 6; i++) begin
                fetch_word(32'h0000_0900 + 32'(4 * i));
            end
        end

        // Boot window on both ports
        for (int i = 0; i < memsys_pkg::BOOT_WORDS; i++) begin
            fetch_word(memsys_pkg::BOOT_BASE + 32'(4 * i));
            boot_load(memsys_pkg::BOOT_BASE + 32'(4 * i));
        end

        // Killed fetch, then fetch and load racing for main memory
        for (int i = 0; i < 4; i++) begin
            store_word(32'h0000_0a00 + 32'(4 * i), $random(seed), 4'hf);
        end
        kill_fetch(32'h0000_0a00);
        fetch_word(32'h0000_0a04);
        fetch_word(32'h0000_0a00);
        for (int r = 0; r < 2; r++) begin
            fork
                fetch_word(32'h0000_0a08);
                load_word(32'h0000_0a0c);
            join
        end

        repeat (4) @(negedge clk);
        $display("errors: %0d mismatches, %0d unexpected acks, %0d timeouts, %0d idle",
                 err_mismatch, err_unexpected, err_timeout, err_idle);
        if (err_mismatch + err_unexpected + err_timeout + err_idle == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* memsys.f */
hw/memsys_pkg.sv
hw/icache.sv
hw/dcache.sv
hw/mem_arbiter.sv
hw/main_mem.sv
hw/boot_rom.sv
hw/memsys_top.sv
tb/memsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module memsys_tb -f memsys.f -o memsys_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memsys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* boot_rom.hex */
// One 32-bit word per line, boot window word 0 (address 0x0000_1000) first
00001137
0ff00093
00102023
00402103
deadbeef
13572468
a5a5a5a5
5a5a5a5a
0badc0de
00c0ffee
fedcba98
76543210
11223344
55667788
99aabbcc
ddeeff00
